/* verilog.f */
+incdir+source
source/cpu_pkg.sv
source/instr_fetch.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
testbench/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build the cpu testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cpu_tb \
    -f verilog.f -Mdir obj_dir -o cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cpu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

/* testbench/cpu_tb.sv */
//==========================================================
// cpu testbench: loads a program over the byte loader and
// checks registers and data memory through the readout mux
//==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int PROG_LEN   = 12;
    localparam int NUM_CHECKS = 15;
    localparam int LOAD_BYTES = PROG_LEN * 4 + 2;    // begin + program + end
    localparam int TIMEOUT    = LOAD_BYTES + PROG_LEN + NUM_CHECKS * 4 + 50;

    localparam logic [6:0] OP_IMM  = 7'b0010011;    // rv32i opcodes
    localparam logic [6:0] OP_LOAD = 7'b0000011;

    // one readout entry, register file when data_or_reg is set
    typedef struct packed {
        logic       data_or_reg;
        mem_index_t address;
        word_t      word;
    } readout_t;

    logic       clk_i;
    logic       reset;
    byte_t      instr_i;
    logic       data_or_reg_i;
    mem_index_t address_i;
    lane_t      vout_addr_i;
    byte_t      value_o;

    instr_t     program_mem [PROG_LEN];
    readout_t   checks [NUM_CHECKS];
    int         cycle_cnt;

    cpu_top i_dut (
        .clk_i         (clk_i),
        .reset         (reset),
        .instr_i       (instr_i),
        .data_or_reg_i (data_or_reg_i),
        .address_i     (address_i),
        .vout_addr_i   (vout_addr_i),
        .value_o       (value_o)
    );

    // ===================== instruction encoding ============

    function automatic instr_t rtype_word(logic [6:0] funct7, reg_addr_t rs2, reg_addr_t rs1,
                                          logic [2:0] funct3, reg_addr_t rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic instr_t itype_word(logic [11:0] imm, reg_addr_t rs1, logic [2:0] funct3,
                                          reg_addr_t rd, logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic instr_t stype_word(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};    // sw only
    endfunction

    // ===================== program and expected tables =====

    task automatic fill_tables();
        program_mem[0]  = itype_word(12'h123, 5'd0, 3'b000, 5'd1, OP_IMM);     // addi x1,x0,0x123
        program_mem[1]  = itype_word(12'(-86), 5'd0, 3'b000, 5'd2, OP_IMM);    // addi x2,x0,-86
        program_mem[2]  = rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);         // add x3,x1,x2
        program_mem[3]  = rtype_word(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);         // sub x4,x3,x1
        program_mem[4]  = rtype_word(7'h00, 5'd3, 5'd4, 3'b111, 5'd5);         // and x5,x4,x3
        program_mem[5]  = rtype_word(7'h00, 5'd1, 5'd5, 3'b110, 5'd6);         // or x6,x5,x1
        program_mem[6]  = stype_word(12'd8, 5'd6, 5'd0);                       // sw x6,8(x0)
        program_mem[7]  = itype_word(12'd8, 5'd0, 3'b010, 5'd7, OP_LOAD);      // lw x7,8(x0)
        program_mem[8]  = rtype_word(7'h00, 5'd2, 5'd7, 3'b000, 5'd8);         // add x8,x7,x2
        program_mem[9]  = stype_word(12'd4, 5'd8, 5'd0);                       // sw x8,4(x0)
        program_mem[10] = stype_word(12'd16, 5'd3, 5'd2);                      // sw x3,16(x2)
        program_mem[11] = itype_word(12'h7FF, 5'd0, 3'b000, 5'd0, OP_IMM);     // addi x0,x0,0x7ff

        checks[0]  = '{1'b1, 5'd1,  32'h0000_0123};
        checks[1]  = '{1'b1, 5'd2,  32'hFFFF_FFAA};    // -86 sign extended
        checks[2]  = '{1'b1, 5'd3,  32'h0000_00CD};    // 0x123 - 0x56
        checks[3]  = '{1'b1, 5'd4,  32'hFFFF_FFAA};    // 0xcd - 0x123
        checks[4]  = '{1'b1, 5'd5,  32'h0000_0088};    // 0x..aa & 0xcd
        checks[5]  = '{1'b1, 5'd6,  32'h0000_01AB};    // 0x88 | 0x123
        checks[6]  = '{1'b1, 5'd7,  32'h0000_01AB};    // loaded back
        checks[7]  = '{1'b1, 5'd8,  32'h0000_0155};    // 0x1ab - 0x56 after stall
        checks[8]  = '{1'b1, 5'd0,  32'h0000_0000};    // x0 write dropped
        checks[9]  = '{1'b1, 5'd9,  32'h0000_0000};    // never written
        checks[10] = '{1'b1, 5'd31, 32'h0000_0000};
        checks[11] = '{1'b0, 5'd2,  32'h0000_01AB};    // byte addr 8
        checks[12] = '{1'b0, 5'd1,  32'h0000_0155};    // byte addr 4
        checks[13] = '{1'b0, 5'd14, 32'h0000_00CD};    // 0xffffffba, bits 6:2 = 14
        checks[14] = '{1'b0, 5'd0,  32'h0000_0000};
    endtask

    // ===================== loader ==========================

    task automatic send_byte(byte_t b);
        @(posedge clk_i);
        instr_i <= b;    // sampled at the next edge
    endtask

    task automatic load_program();
        byte_t cur;
        send_byte(`CPU_LOAD_BEGIN);
        for (int w = 0; w < PROG_LEN; w++) begin
            for (int b = 0; b < 4; b++) begin
                cur = program_mem[w][8*b +: 8];    // little-endian
                if (cur == `CPU_LOAD_BEGIN || cur == `CPU_LOAD_END) begin
                    $display("program word %0d byte %0d collides with a loader marker", w, b);
                    $display("ERRORS FOUND");
                    $fatal(1, "bad program table");
                end
                send_byte(cur);
            end
        end
        send_byte(`CPU_LOAD_END);
        send_byte(8'h00);    // ignored once running
    endtask

    // ===================== readout checks ==================

    task automatic run_checks();
        byte_t exp_byte;
        for (int c = 0; c < NUM_CHECKS; c++) begin
            for (int lane = 0; lane < 4; lane++) begin
                @(posedge clk_i);
                data_or_reg_i <= checks[c].data_or_reg;
                address_i     <= checks[c].address;
                vout_addr_i   <= lane_t'(lane);
                @(negedge clk_i);    // readout settled mid-cycle
                exp_byte = checks[c].word[8*lane +: 8];
                assert (value_o === exp_byte) else begin
                    $display("FAIL t=%0t value_o (%s %0d lane %0d) expected %h got %h",
                             $time, checks[c].data_or_reg ? "reg" : "mem",
                             checks[c].address, lane, exp_byte, value_o);
                    $display("ERRORS FOUND");
                    $fatal(1, "readout mismatch");
                end
            end
        end
    endtask

    // ===================== clock, watchdog, main ===========

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;    // 4 ns period
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("run reached the %0d cycle limit before the checks finished", TIMEOUT);
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    initial begin
        reset         = 1'b1;
        instr_i       = '0;
        data_or_reg_i = 1'b1;
        address_i     = '0;
        vout_addr_i   = '0;
        fill_tables();
        repeat (5) @(posedge clk_i);
        reset <= 1'b0;
        load_program();
        repeat (PROG_LEN + 10) @(posedge clk_i);    // drain pipeline
        run_checks();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* source/cpu_top.sv */
//==========================================================
// five-stage rv32i subset core with byte loader and readout
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic       clk_i,
    input  logic       reset,
    input  byte_t      instr_i,
    input  logic       data_or_reg_i,   // 1 register file, 0 data memory
    input  mem_index_t address_i,
    input  lane_t      vout_addr_i,
    output byte_t      value_o
);

    instr_t    fetch_instr;
    logic      fetch_valid;
    logic      stall;
    id_ex_t    id_ex;
    logic      id_ex_valid;
    ex_mem_t   ex_mem;
    logic      ex_mem_valid;
    logic      ex_mem_read;
    reg_addr_t ex_rd;
    wb_t       wb;              // regfile write and mem/wb forward
    word_t     reg_debug, mem_debug, debug_word;

    instr_fetch u_instr_fetch (
        .clk_i         (clk_i),
        .reset         (reset),
        .instr_i       (instr_i),
        .stall_i       (stall),
        .fetch_instr_o (fetch_instr),
        .fetch_valid_o (fetch_valid)
    );

    decode_stage u_decode_stage (
        .clk_i         (clk_i),
        .reset         (reset),
        .fetch_instr_i (fetch_instr),
        .fetch_valid_i (fetch_valid),
        .ex_mem_read_i (ex_mem_read),
        .ex_rd_i       (ex_rd),
        .wb_i          (wb),
        .debug_addr_i  (address_i),
        .reg_debug_o   (reg_debug),
        .stall_o       (stall),
        .id_ex_o       (id_ex),
        .id_ex_valid_o (id_ex_valid)
    );

    execute_stage u_execute_stage (
        .clk_i          (clk_i),
        .reset          (reset),
        .id_ex_i        (id_ex),
        .id_ex_valid_i  (id_ex_valid),
        .wb_i           (wb),
        .ex_mem_o       (ex_mem),
        .ex_mem_valid_o (ex_mem_valid),
        .ex_mem_read_o  (ex_mem_read),
        .ex_rd_o        (ex_rd)
    );

    memory_stage u_memory_stage (
        .clk_i          (clk_i),
        .reset          (reset),
        .ex_mem_i       (ex_mem),
        .ex_mem_valid_i (ex_mem_valid),
        .debug_addr_i   (address_i),
        .wb_o           (wb),
        .debug_data_o   (mem_debug)
    );

    // ===================== debug readout ===================

    assign debug_word = data_or_reg_i ? reg_debug : mem_debug;
    assign value_o    = debug_word[{vout_addr_i, 3'b000} +: 8];    // lane 0 = bits 7:0

endmodule

`default_nettype wire

/* source/memory_stage.sv */
//==========================================================
// memory stage: data memory and mem/wb register
//==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module memory_stage import cpu_pkg::*; (
    input  logic       clk_i,
    input  logic       reset,
    input  ex_mem_t    ex_mem_i,
    input  logic       ex_mem_valid_i,
    input  mem_index_t debug_addr_i,
    output wb_t        wb_o,
    output word_t      debug_data_o
);

    localparam int IDX_HI = $clog2(`CPU_DMEM_WORDS) + 1;

    word_t      dmem [`CPU_DMEM_WORDS];
    mem_index_t dm_idx;
    word_t      load_data;
    wb_t        wb_q;

    assign dm_idx    = ex_mem_i.alu_result[IDX_HI:2];    // word index from byte address
    assign load_data = dmem[dm_idx];

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CPU_DMEM_WORDS; i++) dmem[i] <= '0;
        end else if (ex_mem_valid_i && ex_mem_i.ctrl.mem_write) begin
            dmem[dm_idx] <= ex_mem_i.store_data;
        end
    end

    // ===================== mem/wb ==========================

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            wb_q <= '0;
        end else begin
            wb_q.reg_write <= ex_mem_valid_i && ex_mem_i.ctrl.reg_write;
            wb_q.rd        <= ex_mem_i.rd;
            wb_q.data      <= ex_mem_i.ctrl.mem_to_reg ? load_data : ex_mem_i.alu_result;
        end
    end

    assign wb_o         = wb_q;
    assign debug_data_o = dmem[debug_addr_i];

endmodule

`default_nettype wire

/* source/execute_stage.sv */
//==========================================================
// execute: operand forwarding, alu and ex/mem register
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  logic      clk_i,
    input  logic      reset,
    input  id_ex_t    id_ex_i,
    input  logic      id_ex_valid_i,
    input  wb_t       wb_i,             // mem/wb forward source
    output ex_mem_t   ex_mem_o,
    output logic      ex_mem_valid_o,
    output logic      ex_mem_read_o,    // to hazard check
    output reg_addr_t ex_rd_o
);

    ex_mem_t  ex_mem_q;
    logic     ex_mem_valid_q;
    fwd_sel_t fwd_a, fwd_b;
    word_t    op_a, rs2_val, op_b;
    word_t    alu_y;

    // younger ex/mem result beats mem/wb, x0 never forwarded
    function automatic fwd_sel_t pick_fwd(reg_addr_t rs);
        fwd_sel_t sel;
        sel = FWD_REG;
        if (rs != '0) begin
            if (ex_mem_valid_q && ex_mem_q.ctrl.reg_write && ex_mem_q.rd == rs) begin
                sel = FWD_EX_MEM;
            end else if (wb_i.reg_write && wb_i.rd == rs) begin
                sel = FWD_MEM_WB;
            end
        end
        return sel;
    endfunction

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val);
        case (sel)
            FWD_EX_MEM: return ex_mem_q.alu_result;
            FWD_MEM_WB: return wb_i.data;
            default:    return reg_val;
        endcase
    endfunction

    always_comb begin
        fwd_a   = pick_fwd(id_ex_i.rs1);
        fwd_b   = pick_fwd(id_ex_i.rs2);
        op_a    = fwd_mux(fwd_a, id_ex_i.rs1_data);
        rs2_val = fwd_mux(fwd_b, id_ex_i.rs2_data);    // also the store data
        op_b    = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : rs2_val;
        case (id_ex_i.ctrl.alu_op)
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            default: alu_y = op_a + op_b;    // add, addi, lw/sw address
        endcase
    end

    // ===================== ex/mem ==========================

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) ex_mem_valid_q <= 1'b0;
        else ex_mem_valid_q <= id_ex_valid_i;
    end

    always_ff @(posedge clk_i) begin
        ex_mem_q.ctrl       <= id_ex_i.ctrl;
        ex_mem_q.alu_result <= alu_y;
        ex_mem_q.store_data <= rs2_val;
        ex_mem_q.rd         <= id_ex_i.rd;
    end

    assign ex_mem_o       = ex_mem_q;
    assign ex_mem_valid_o = ex_mem_valid_q;
    assign ex_mem_read_o  = id_ex_valid_i && id_ex_i.ctrl.mem_read;
    assign ex_rd_o        = id_ex_i.rd;

endmodule

`default_nettype wire

/* source/decode_stage.sv */
//==========================================================
// decode: if/id, control, immediates, load-use stall, id/ex
//==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module decode_stage import cpu_pkg::*; (
    input  logic       clk_i,
    input  logic       reset,
    input  instr_t     fetch_instr_i,
    input  logic       fetch_valid_i,
    input  logic       ex_mem_read_i,   // lw sitting in ex
    input  reg_addr_t  ex_rd_i,
    input  wb_t        wb_i,
    input  mem_index_t debug_addr_i,
    output word_t      reg_debug_o,
    output logic       stall_o,
    output id_ex_t     id_ex_o,
    output logic       id_ex_valid_o
);

    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    instr_t    if_id_q;
    logic      if_id_valid_q;
    reg_addr_t rs1, rs2;
    word_t     rs1_data, rs2_data;
    ctrl_t     ctrl;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    logic      id_ex_valid_q;

    // ===================== if/id ===========================

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) if_id_valid_q <= 1'b0;
        else if (!stall_o) if_id_valid_q <= fetch_valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (!stall_o) if_id_q <= fetch_instr_i;    // held during stall
    end

    assign rs1 = if_id_q[19:15];
    assign rs2 = if_id_q[24:20];

    register_file u_register_file (
        .clk_i        (clk_i),
        .reset        (reset),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .wb_i         (wb_i),
        .debug_addr_i (debug_addr_i),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .debug_data_o (reg_debug_o)
    );

    // ===================== control decode ==================

    always_comb begin
        ctrl = '0;    // unknown opcode -> no-op
        case (if_id_q[6:0])
            OP_REG: begin
                ctrl.reg_write = 1'b1;
                case (if_id_q[14:12])
                    3'b000:  ctrl.alu_op = if_id_q[30] ? ALU_SUB : ALU_ADD;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_IMM: begin
                ctrl.alu_src_imm = (if_id_q[14:12] == 3'b000);    // addi only
                ctrl.reg_write   = (if_id_q[14:12] == 3'b000);
            end
            OP_LOAD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
            end
            OP_STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            default: ;
        endcase
    end

    // load-use: lw in ex feeds an operand of the instr in id
    assign stall_o = if_id_valid_q && ex_mem_read_i && ex_rd_i != '0 &&
                     (ex_rd_i == rs1 || ex_rd_i == rs2);

    always_comb begin
        id_ex_d.ctrl     = ctrl;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = ctrl.mem_write
            ? {{(`CPU_XLEN-12){if_id_q[31]}}, if_id_q[31:25], if_id_q[11:7]}    // s-type
            : {{(`CPU_XLEN-12){if_id_q[31]}}, if_id_q[31:20]};                  // i-type
        id_ex_d.rs1      = rs1;
        id_ex_d.rs2      = rs2;
        id_ex_d.rd       = if_id_q[11:7];
    end

    // ===================== id/ex ===========================

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) id_ex_valid_q <= 1'b0;
        else id_ex_valid_q <= if_id_valid_q && !stall_o;    // bubble on stall
    end

    always_ff @(posedge clk_i) begin
        id_ex_q <= id_ex_d;
    end

    assign id_ex_o       = id_ex_q;
    assign id_ex_valid_o = id_ex_valid_q;

    // the bubble clears the lw from ex, so a stall lasts one cycle
    a_stall_single: assert property (@(posedge clk_i) disable iff (reset)
        stall_o |=> !stall_o)
        else $error("load-use stall held for two cycles");

endmodule

`default_nettype wire

/* source/register_file.sv */
//==========================================================
// register file, 2 read ports with write-first bypass
//==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module register_file import cpu_pkg::*; (
    input  logic       clk_i,
    input  logic       reset,
    input  reg_addr_t  rs1_i,
    input  reg_addr_t  rs2_i,
    input  wb_t        wb_i,            // writeback from mem/wb
    input  mem_index_t debug_addr_i,
    output word_t      rs1_data_o,
    output word_t      rs2_data_o,
    output word_t      debug_data_o
);

    word_t regs [2**`CPU_REG_AW];

    // x0 reads zero, same-cycle write wins over the stored value
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) return '0;
        if (wb_i.reg_write && wb_i.rd == addr) return wb_i.data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**`CPU_REG_AW; i++) regs[i] <= '0;
        end else if (wb_i.reg_write && wb_i.rd != '0) begin    // x0 never stored
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    assign rs1_data_o   = read_port(rs1_i);
    assign rs2_data_o   = read_port(rs2_i);
    assign debug_data_o = regs[debug_addr_i];    // stored value only

    a_x0_zero: assert property (@(posedge clk_i) disable iff (reset)
        debug_addr_i == '0 |-> debug_data_o == '0)
        else $error("register 0 holds a nonzero value");

endmodule

`default_nettype wire

/* source/instr_fetch.sv */
//==========================================================
// instruction fetch: byte loader fsm, imem and pc
//==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module instr_fetch import cpu_pkg::*; (
    input  logic   clk_i,
    input  logic   reset,
    input  byte_t  instr_i,         // loader byte stream
    input  logic   stall_i,         // load-use hold
    output instr_t fetch_instr_o,
    output logic   fetch_valid_o
);

    localparam int CNT_W = $clog2(`CPU_IMEM_WORDS) + 2;    // word index plus lane

    load_state_t      state_q;
    logic [CNT_W-1:0] byte_cnt_q;    // bytes written so far
    mem_index_t       pc_q;
    instr_t           imem [`CPU_IMEM_WORDS];
    logic             imem_we;
    mem_index_t       wr_word;
    lane_t            wr_lane;

    assign imem_we = (state_q == LOAD_FILL) && (instr_i != `CPU_LOAD_END);
    assign wr_word = byte_cnt_q[CNT_W-1:2];
    assign wr_lane = byte_cnt_q[1:0];    // little-endian within the word

    // ===================== loader fsm ======================

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            state_q    <= LOAD_IDLE;
            byte_cnt_q <= '0;
        end else begin
            case (state_q)
                LOAD_IDLE: begin
                    if (instr_i == `CPU_LOAD_BEGIN) state_q <= LOAD_FILL;
                end
                LOAD_FILL: begin
                    if (instr_i == `CPU_LOAD_END) begin
                        state_q <= LOAD_RUN;
                    end else begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                    end
                end
                default: ;    // run until reset
            endcase
        end
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CPU_IMEM_WORDS; i++) imem[i] <= '0;    // zero = no-op
        end else if (imem_we) begin
            imem[wr_word][{wr_lane, 3'b000} +: 8] <= instr_i;
        end
    end

    // ===================== program counter =================

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            pc_q <= '0;
        end else if (state_q == LOAD_RUN && !stall_i &&
                     pc_q != mem_index_t'(`CPU_IMEM_WORDS - 1)) begin
            pc_q <= pc_q + 1'b1;    // parks on last word
        end
    end

    assign fetch_instr_o = imem[pc_q];
    assign fetch_valid_o = (state_q == LOAD_RUN);

    // once running, the fsm stays there and a held pc keeps showing the same word
    a_run_frozen: assert property (@(posedge clk_i) disable iff (reset)
        state_q == LOAD_RUN |=> state_q == LOAD_RUN &&
            (pc_q != $past(pc_q) || fetch_instr_o == $past(fetch_instr_o)))
        else $error("imem written or loader left run state");

endmodule

`default_nettype wire

/* source/cpu_pkg.sv */
//==========================================================
// cpu types: word widths, fsm enums, pipeline payloads
//==========================================================
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

    // ====================== plain vectors ======================

    typedef logic [`CPU_XLEN-1:0]                word_t;
    typedef logic [`CPU_XLEN-1:0]                instr_t;
    typedef logic [`CPU_REG_AW-1:0]              reg_addr_t;
    typedef logic [$clog2(`CPU_IMEM_WORDS)-1:0]  mem_index_t;   // same depth for dmem
    typedef logic [7:0]                          byte_t;
    typedef logic [$clog2(`CPU_XLEN/8)-1:0]      lane_t;

    // ====================== enums ==============================

    typedef enum logic [1:0] {
        LOAD_IDLE,      // waiting for begin marker
        LOAD_FILL,      // bytes go to imem
        LOAD_RUN        // program running until reset
    } load_state_t;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} alu_op_t;

    typedef enum logic [1:0] {FWD_REG, FWD_EX_MEM, FWD_MEM_WB} fwd_sel_t;

    // ====================== pipeline payloads ==================

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src_imm;   // operand b from immediate
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;    // writeback takes load data
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;  // also the dmem byte address
        word_t     store_data;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

/* source/cpu_macros.svh */
//==========================================================
// cpu widths, memory depths and loader marker bytes
//==========================================================
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ========================= datapath ========================

`define CPU_XLEN        32      // data word and instruction width
`define CPU_REG_AW      5       // register number width, 32 registers

// ========================= memories ========================

`define CPU_IMEM_WORDS  32      // instruction memory depth
`define CPU_DMEM_WORDS  32      // data memory depth

// ========================= loader ==========================

`define CPU_LOAD_BEGIN  8'hFE   // enter fill mode
`define CPU_LOAD_END    8'hFF   // stop filling, start running

`endif
